/* verilog/mc_adapter_pkg.sv */
// Shared definitions for the memory channel adapter
// Data, address and tag widths, opcode, status-bit and init-state enums,
// and the request and response records carried through the queues

package mc_adapter_pkg;

  // ------------------------------------------------------------
  // Widths
  // ------------------------------------------------------------
  localparam int DATA_WIDTH      = 64;
  localparam int BE_WIDTH        = DATA_WIDTH / 8;
  localparam int HOST_ADDR_WIDTH = 16;
  localparam int MDATA_WIDTH     = 14;
  localparam int STATUS_WIDTH    = 5;

  // ------------------------------------------------------------
  // Enums
  // ------------------------------------------------------------
  typedef enum logic {
    REQ_READ  = 1'b0,
    REQ_WRITE = 1'b1
  } req_op_e;

  // Bit positions inside the status bus
  typedef enum logic [2:0] {
    STAT_CAL_FAIL      = 3'd0,
    STAT_CAL_SUCCESS   = 3'd1,
    STAT_RESET_DONE    = 3'd2,
    STAT_PLL_LOCKED    = 3'd3,
    STAT_RAM_INIT_DONE = 3'd4
  } status_bit_e;

  typedef enum logic {
    INIT_FILL,
    INIT_DONE
  } init_state_e;

  // ------------------------------------------------------------
  // Queue records
  // ------------------------------------------------------------
  // Address is the offset from the base, still at host width
  typedef struct packed {
    req_op_e                    op;
    logic                       write_poison;
    logic [BE_WIDTH-1:0]        byteenable;
    logic [HOST_ADDR_WIDTH-1:0] address;
    logic [DATA_WIDTH-1:0]      writedata;
    logic [MDATA_WIDTH-1:0]     mdata;
  } req_t;

  typedef struct packed {
    logic                   read_poison;
    logic [MDATA_WIDTH-1:0] mdata;
    logic [DATA_WIDTH-1:0]  readdata;
  } rsp_t;

endpackage

/* verilog/mc_sync_fifo.sv */
// Single-clock FIFO built from a register array
// Read and write pointers plus an occupancy count, head shown on pop_data

`timescale 1ns/1ps

module mc_sync_fifo #(
  parameter int WIDTH       = 8,
  parameter int DEPTH_WIDTH = 3
) (
  input  logic             emif_usr_clk,
  input  logic             reset_n_eclk,
  input  logic             push,
  input  logic [WIDTH-1:0] push_data,
  input  logic             pop,
  output logic [WIDTH-1:0] pop_data,
  output logic             empty,
  output logic             full
);

  localparam int DEPTH = 1 << DEPTH_WIDTH;

  logic [WIDTH-1:0]       fifo_mem [DEPTH];
  logic [DEPTH_WIDTH-1:0] wr_ptr;
  logic [DEPTH_WIDTH-1:0] rd_ptr;
  logic [DEPTH_WIDTH:0]   count;
  logic                   do_push;
  logic                   do_pop;

  // A push into a full FIFO or a pop from an empty one is dropped
  assign do_push = push & ~full;
  assign do_pop  = pop & ~empty;

  assign empty = (count == '0);
  // Count never exceeds DEPTH, so its top bit alone marks full
  assign full  = count[DEPTH_WIDTH];

  assign pop_data = fifo_mem[rd_ptr];

  always_ff @(posedge emif_usr_clk) begin
    if (do_push) begin
      fifo_mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge emif_usr_clk) begin
    if (!reset_n_eclk) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

/* verilog/mc_req_capture.sv */
// Host request acceptance and the request queue
// Ready generation, base-relative address translation and req_t packing

`timescale 1ns/1ps

module mc_req_capture
  import mc_adapter_pkg::*;
#(
  parameter int REQ_DEPTH_WIDTH = 3
) (
  input  logic                       emif_usr_clk,
  input  logic                       reset_n_eclk,
  input  logic [HOST_ADDR_WIDTH-1:0] base_addr,
  input  logic                       base_addr_vld,
  input  logic                       read,
  input  logic                       write,
  input  logic                       write_poison,
  input  logic [HOST_ADDR_WIDTH-1:0] address,
  input  logic [DATA_WIDTH-1:0]      writedata,
  input  logic [BE_WIDTH-1:0]        byteenable,
  input  logic [MDATA_WIDTH-1:0]     req_mdata,
  input  logic                       init_done,
  output logic                       ready,
  output req_t                       req_head,
  output logic                       req_empty,
  input  logic                       req_pop
);

  logic                       req_full;
  logic                       accept;
  logic [HOST_ADDR_WIDTH-1:0] addr_offset;
  req_t                       req_in;

  // Ready drops in the same cycle the queue fills
  assign ready  = ~req_full & init_done & base_addr_vld;
  assign accept = ready & (read | write);

  // The base address is held at half resolution, hence the shift
  assign addr_offset = address - {1'b0, base_addr[HOST_ADDR_WIDTH-1:1]};

  always_comb begin
    // Write wins if the host raises both strobes
    req_in.op           = write ? REQ_WRITE : REQ_READ;
    req_in.write_poison = write_poison;
    req_in.byteenable   = byteenable;
    req_in.address      = addr_offset;
    req_in.writedata    = writedata;
    req_in.mdata        = req_mdata;
  end

  mc_sync_fifo #(
    .WIDTH       ($bits(req_t)),
    .DEPTH_WIDTH (REQ_DEPTH_WIDTH)
  ) u_req_fifo (
    .emif_usr_clk (emif_usr_clk),
    .reset_n_eclk (reset_n_eclk),
    .push         (accept),
    .push_data    (req_in),
    .pop          (req_pop),
    .pop_data     (req_head),
    .empty        (req_empty),
    .full         (req_full)
  );

endmodule

/* verilog/mc_init_status.sv */
// Zero-fill RAM init sequencer and the five-bit status register

`timescale 1ns/1ps

module mc_init_status
  import mc_adapter_pkg::*;
#(
  parameter int MEM_ADDR_WIDTH = 6
) (
  input  logic                      emif_usr_clk,
  input  logic                      reset_n_eclk,
  input  logic                      mem_ready,
  input  logic                      emif_cal_fail,
  input  logic                      emif_cal_success,
  input  logic                      emif_reset_done,
  input  logic                      emif_pll_locked,
  output logic                      init_done,
  output logic [MEM_ADDR_WIDTH-1:0] init_addr,
  output logic [STATUS_WIDTH-1:0]   status
);

  init_state_e state;
  init_state_e state_next;
  logic        fill_step;

  // ------------------------------------------------------------
  // Init sequencer
  // ------------------------------------------------------------
  // One address per edge on which the memory takes the fill write
  assign fill_step = (state == INIT_FILL) & mem_ready;

  always_comb begin
    state_next = state;
    if (fill_step && (init_addr == '1)) begin
      state_next = INIT_DONE;
    end
  end

  assign init_done = (state == INIT_DONE);

  // The fill command is also shown while reset is held, with the
  // address pinned at 0 until reset is released
  always_ff @(posedge emif_usr_clk) begin
    if (!reset_n_eclk) begin
      state     <= INIT_FILL;
      init_addr <= '0;
    end else begin
      state <= state_next;
      if (fill_step) begin
        init_addr <= init_addr + 1'b1;
      end
    end
  end

  // ------------------------------------------------------------
  // Status register
  // ------------------------------------------------------------
  always_ff @(posedge emif_usr_clk) begin
    if (!reset_n_eclk) begin
      status <= '0;
    end else begin
      status[STAT_CAL_FAIL]    <= emif_cal_fail;
      status[STAT_CAL_SUCCESS] <= emif_cal_success;
      status[STAT_RESET_DONE]  <= emif_reset_done;
      status[STAT_PLL_LOCKED]  <= emif_pll_locked;
      // Set on the same edge as init_done so ready never leads it
      status[STAT_RAM_INIT_DONE] <= (state_next == INIT_DONE);
    end
  end

endmodule

/* verilog/mc_mem_issue.sv */
// Memory command port driver
// Muxes zero-fill writes during init and queued requests afterwards

`timescale 1ns/1ps

module mc_mem_issue
  import mc_adapter_pkg::*;
#(
  parameter int MEM_ADDR_WIDTH = 6
) (
  input  logic                      init_done,
  input  logic [MEM_ADDR_WIDTH-1:0] init_addr,
  input  logic                      mem_ready,
  input  req_t                      req_head,
  input  logic                      req_empty,
  output logic                      req_pop,
  output logic                      mem_read,
  output logic                      mem_write,
  output logic [MEM_ADDR_WIDTH-1:0] mem_address,
  output logic [DATA_WIDTH-1:0]     mem_writedata,
  output logic [BE_WIDTH-1:0]       mem_byteenable,
  output logic                      mem_write_poison,
  output logic                      read_taken,
  output logic [MDATA_WIDTH-1:0]    read_mdata
);

  logic head_valid;

  assign head_valid = ~req_empty;

  // Commands come straight from the queue head, so a command is held
  // for as long as mem_ready stays low and the head is not popped
  always_comb begin
    if (!init_done) begin
      mem_read         = 1'b0;
      mem_write        = 1'b1;
      mem_address      = init_addr;
      mem_writedata    = '0;
      mem_byteenable   = '1;
      mem_write_poison = 1'b0;
      req_pop          = 1'b0;
    end else begin
      mem_read         = head_valid & (req_head.op == REQ_READ);
      mem_write        = head_valid & (req_head.op == REQ_WRITE);
      mem_address      = req_head.address[MEM_ADDR_WIDTH-1:0];
      mem_writedata    = req_head.writedata;
      mem_byteenable   = req_head.byteenable;
      mem_write_poison = req_head.write_poison;
      req_pop          = head_valid & mem_ready;
    end
  end

  // Tag of a read goes to the response side on the edge it is taken
  assign read_taken = mem_read & mem_ready;
  assign read_mdata = req_head.mdata;

endmodule

/* verilog/mc_rsp_path.sv */
// Response side with the read-tag queue, response queue and host outputs
// Memory returns reads in order, so each word pairs with the oldest tag

`timescale 1ns/1ps

module mc_rsp_path
  import mc_adapter_pkg::*;
#(
  parameter int RSP_DEPTH_WIDTH = 4
) (
  input  logic                   emif_usr_clk,
  input  logic                   reset_n_eclk,
  input  logic                   read_taken,
  input  logic [MDATA_WIDTH-1:0] read_mdata,
  input  logic                   mem_readdatavalid,
  input  logic [DATA_WIDTH-1:0]  mem_readdata,
  input  logic                   mem_read_poison,
  output logic                   readdatavalid,
  output logic [DATA_WIDTH-1:0]  readdata,
  output logic [MDATA_WIDTH-1:0] rsp_mdata,
  output logic                   read_poison
);

  logic [MDATA_WIDTH-1:0] tag_head;
  logic                   rsp_empty;
  rsp_t                   rsp_in;
  rsp_t                   rsp_head;

  mc_sync_fifo #(
    .WIDTH       (MDATA_WIDTH),
    .DEPTH_WIDTH (RSP_DEPTH_WIDTH)
  ) u_tag_fifo (
    .emif_usr_clk (emif_usr_clk),
    .reset_n_eclk (reset_n_eclk),
    .push         (read_taken),
    .push_data    (read_mdata),
    .pop          (mem_readdatavalid),
    .pop_data     (tag_head),
    .empty        (),
    .full         ()
  );

  always_comb begin
    rsp_in.read_poison = mem_read_poison;
    rsp_in.mdata       = tag_head;
    rsp_in.readdata    = mem_readdata;
  end

  // There is no back-pressure toward the memory, so the queue drains every cycle
  mc_sync_fifo #(
    .WIDTH       ($bits(rsp_t)),
    .DEPTH_WIDTH (RSP_DEPTH_WIDTH)
  ) u_rsp_fifo (
    .emif_usr_clk (emif_usr_clk),
    .reset_n_eclk (reset_n_eclk),
    .push         (mem_readdatavalid),
    .push_data    (rsp_in),
    .pop          (~rsp_empty),
    .pop_data     (rsp_head),
    .empty        (rsp_empty),
    .full         ()
  );

  assign readdatavalid = ~rsp_empty;
  assign readdata      = rsp_head.readdata;
  assign rsp_mdata     = rsp_head.mdata;
  assign read_poison   = rsp_head.read_poison;

endmodule

/* verilog/mc_channel_adapter.sv */
// Memory channel adapter top level
// Host request and response ports, memory command port and status bus

`timescale 1ns/1ps

module mc_channel_adapter
  import mc_adapter_pkg::*;
#(
  parameter int MEM_ADDR_WIDTH  = 6,
  parameter int REQ_DEPTH_WIDTH = 3,
  parameter int RSP_DEPTH_WIDTH = 4
) (
  input  logic                       emif_usr_clk,
  input  logic                       reset_n_eclk,

  // Host side
  input  logic [HOST_ADDR_WIDTH-1:0] base_addr,
  input  logic                       base_addr_vld,
  output logic                       ready,
  input  logic                       read,
  input  logic                       write,
  input  logic                       write_poison,
  input  logic [HOST_ADDR_WIDTH-1:0] address,
  input  logic [MDATA_WIDTH-1:0]     req_mdata,
  input  logic [DATA_WIDTH-1:0]      writedata,
  input  logic [BE_WIDTH-1:0]        byteenable,
  output logic [DATA_WIDTH-1:0]      readdata,
  output logic [MDATA_WIDTH-1:0]     rsp_mdata,
  output logic                       read_poison,
  output logic                       readdatavalid,

  // Controller status
  input  logic                       emif_pll_locked,
  input  logic                       emif_reset_done,
  input  logic                       emif_cal_success,
  input  logic                       emif_cal_fail,
  output logic [STATUS_WIDTH-1:0]    status,

  // Memory command port
  input  logic                       mem_ready,
  output logic                       mem_read,
  output logic                       mem_write,
  output logic [MEM_ADDR_WIDTH-1:0]  mem_address,
  output logic [DATA_WIDTH-1:0]      mem_writedata,
  output logic [BE_WIDTH-1:0]        mem_byteenable,
  output logic                       mem_write_poison,
  input  logic                       mem_readdatavalid,
  input  logic [DATA_WIDTH-1:0]      mem_readdata,
  input  logic                       mem_read_poison
);

  logic                      init_done;
  logic [MEM_ADDR_WIDTH-1:0] init_addr;
  req_t                      req_head;
  logic                      req_empty;
  logic                      req_pop;
  logic                      read_taken;
  logic [MDATA_WIDTH-1:0]    read_mdata;

  mc_req_capture #(
    .REQ_DEPTH_WIDTH (REQ_DEPTH_WIDTH)
  ) u_req_capture (
    .emif_usr_clk  (emif_usr_clk),
    .reset_n_eclk  (reset_n_eclk),
    .base_addr     (base_addr),
    .base_addr_vld (base_addr_vld),
    .read          (read),
    .write         (write),
    .write_poison  (write_poison),
    .address       (address),
    .writedata     (writedata),
    .byteenable    (byteenable),
    .req_mdata     (req_mdata),
    .init_done     (init_done),
    .ready         (ready),
    .req_head      (req_head),
    .req_empty     (req_empty),
    .req_pop       (req_pop)
  );

  mc_init_status #(
    .MEM_ADDR_WIDTH (MEM_ADDR_WIDTH)
  ) u_init_status (
    .emif_usr_clk     (emif_usr_clk),
    .reset_n_eclk     (reset_n_eclk),
    .mem_ready        (mem_ready),
    .emif_cal_fail    (emif_cal_fail),
    .emif_cal_success (emif_cal_success),
    .emif_reset_done  (emif_reset_done),
    .emif_pll_locked  (emif_pll_locked),
    .init_done        (init_done),
    .init_addr        (init_addr),
    .status           (status)
  );

  mc_mem_issue #(
    .MEM_ADDR_WIDTH (MEM_ADDR_WIDTH)
  ) u_mem_issue (
    .init_done        (init_done),
    .init_addr        (init_addr),
    .mem_ready        (mem_ready),
    .req_head         (req_head),
    .req_empty        (req_empty),
    .req_pop          (req_pop),
    .mem_read         (mem_read),
    .mem_write        (mem_write),
    .mem_address      (mem_address),
    .mem_writedata    (mem_writedata),
    .mem_byteenable   (mem_byteenable),
    .mem_write_poison (mem_write_poison),
    .read_taken       (read_taken),
    .read_mdata       (read_mdata)
  );

  mc_rsp_path #(
    .RSP_DEPTH_WIDTH (RSP_DEPTH_WIDTH)
  ) u_rsp_path (
    .emif_usr_clk      (emif_usr_clk),
    .reset_n_eclk      (reset_n_eclk),
    .read_taken        (read_taken),
    .read_mdata        (read_mdata),
    .mem_readdatavalid (mem_readdatavalid),
    .mem_readdata      (mem_readdata),
    .mem_read_poison   (mem_read_poison),
    .readdatavalid     (readdatavalid),
    .readdata          (readdata),
    .rsp_mdata         (rsp_mdata),
    .read_poison       (read_poison)
  );

endmodule

/* verification/tb_mem_model.sv */
// Behavioral memory for the channel adapter testbench
// Random ready, in-order reads with varying latency, byte-enable merge
// and one poison bit per word

`timescale 1ns/1ps

module tb_mem_model #(
  parameter int MEM_ADDR_WIDTH = 6
) (
  input  logic                      emif_usr_clk,
  input  logic                      stall,
  input  logic                      mem_read,
  input  logic                      mem_write,
  input  logic [MEM_ADDR_WIDTH-1:0] mem_address,
  input  logic [63:0]               mem_writedata,
  input  logic [7:0]                mem_byteenable,
  input  logic                      mem_write_poison,
  output logic                      mem_ready,
  output logic                      mem_readdatavalid,
  output logic [63:0]               mem_readdata,
  output logic                      mem_read_poison
);

  localparam int WORDS = 1 << MEM_ADDR_WIDTH;

  logic [63:0] mem_data [WORDS];
  logic        mem_poison [WORDS];
  logic [63:0] rd_data_q [$];
  logic        rd_poison_q [$];
  int          rd_due_q [$];
  int          cycle;
  int          last_due;

  initial begin
    // Fill depends on the whole address, so a missed init write shows up
    for (int i = 0; i < WORDS; i++) begin
      mem_data[i]   = {8{i[7:0]}} ^ 64'h5a5a_c3c3_0f0f_9696;
      mem_poison[i] = 1'b1;
    end
    mem_ready         = 1'b0;
    mem_readdatavalid = 1'b0;
    mem_readdata      = '0;
    mem_read_poison   = 1'b0;
    cycle             = 0;
    last_due          = 0;
  end

  always @(posedge emif_usr_clk) begin
    int due;
    if (mem_ready && mem_write) begin
      for (int b = 0; b < 8; b++) begin
        if (mem_byteenable[b]) begin
          mem_data[mem_address][b*8 +: 8] = mem_writedata[b*8 +: 8];
        end
      end
      mem_poison[mem_address] = mem_write_poison;
    end
    if (mem_ready && mem_read) begin
      // Latency varies but answers never overtake each other
      due = cycle + 2 + int'($urandom % 3);
      if (due <= last_due) begin
        due = last_due + 1;
      end
      last_due = due;
      rd_data_q.push_back(mem_data[mem_address]);
      rd_poison_q.push_back(mem_poison[mem_address]);
      rd_due_q.push_back(due);
    end
    cycle = cycle + 1;
    #1;
    mem_readdatavalid = 1'b0;
    if (rd_due_q.size() > 0 && rd_due_q[0] <= cycle) begin
      mem_readdatavalid = 1'b1;
      mem_readdata      = rd_data_q.pop_front();
      mem_read_poison   = rd_poison_q.pop_front();
      void'(rd_due_q.pop_front());
    end
    mem_ready = !stall && (($urandom % 10) < 7);
  end

endmodule

/* verification/tb_mc_channel_adapter.sv */
// Testbench for the memory channel adapter
// Clock, reset, host stimulus, reference memory and checking of the
// init fill, status bits, command port and responses

`timescale 1ns/1ps

module tb_mc_channel_adapter;
  import mc_adapter_pkg::*;

  localparam int MAW = 6;
  localparam int WORDS = 1 << MAW;
  localparam int REQ_DEPTH = 8;
  localparam int MAX_CYCLES = 5000;

  typedef struct packed {
    logic            is_write;
    logic [MAW-1:0]  addr;
    logic [63:0]     data;
    logic [7:0]      be;
    logic            poison;
  } cmd_t;

  typedef struct packed {
    logic [13:0] tag;
    logic [63:0] data;
    logic        poison;
  } rsp_exp_t;

  logic emif_usr_clk = 1'b0;
  logic reset_n_eclk;
  logic [15:0] base_addr;
  logic base_addr_vld;
  logic ready;
  logic read;
  logic write;
  logic write_poison;
  logic [15:0] address;
  logic [13:0] req_mdata;
  logic [13:0] rsp_mdata;
  logic [63:0] writedata;
  logic [63:0] readdata;
  logic [7:0] byteenable;
  logic read_poison;
  logic readdatavalid;
  logic emif_pll_locked;
  logic emif_reset_done;
  logic emif_cal_success;
  logic emif_cal_fail;
  logic [4:0] status;
  logic mem_ready;
  logic mem_read;
  logic mem_write;
  logic mem_write_poison;
  logic [MAW-1:0] mem_address;
  logic [63:0] mem_writedata;
  logic [63:0] mem_readdata;
  logic [7:0] mem_byteenable;
  logic mem_readdatavalid;
  logic mem_read_poison;
  logic stall;

  logic [63:0] ref_data [WORDS];
  logic        ref_poison [WORDS];
  cmd_t        exp_cmd_q [$];
  rsp_exp_t    exp_rsp_q [$];
  int          cycles;
  int          init_count;
  logic [13:0] next_tag;

  always #2 emif_usr_clk = ~emif_usr_clk;

  mc_channel_adapter #(
    .MEM_ADDR_WIDTH  (MAW),
    .REQ_DEPTH_WIDTH (3),
    .RSP_DEPTH_WIDTH (4)
  ) uut (.*);

  tb_mem_model #(.MEM_ADDR_WIDTH(MAW)) u_mem (.*);

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Verification failed");
    $fatal(1);
  endtask

  // Memory word address is the host address less half the base
  function automatic logic [MAW-1:0] to_mem_addr(input logic [15:0] host);
    logic [15:0] diff;
    diff = host - (base_addr >> 1);
    return diff[MAW-1:0];
  endfunction

  // Drives one host request and holds it until a rising edge sees ready high
  task automatic send(input logic is_wr, input logic [15:0] host, input logic [63:0] data,
                      input logic [7:0] be, input logic poison);
    cmd_t     c;
    rsp_exp_t r;
    read = !is_wr;
    write = is_wr;
    address = host;
    writedata = data;
    byteenable = be;
    write_poison = poison;
    req_mdata = next_tag;
    do @(posedge emif_usr_clk); while (!ready);
    c = '{is_write: is_wr, addr: to_mem_addr(host), data: data, be: be, poison: poison};
    exp_cmd_q.push_back(c);
    if (is_wr) begin
      for (int b = 0; b < 8; b++) begin
        if (be[b]) ref_data[c.addr][b*8 +: 8] = data[b*8 +: 8];
      end
      ref_poison[c.addr] = poison;
    end else begin
      r = '{tag: next_tag, data: ref_data[c.addr], poison: ref_poison[c.addr]};
      exp_rsp_q.push_back(r);
    end
    next_tag = next_tag + 14'd1;
    #1;
    read = 1'b0;
    write = 1'b0;
  endtask

  task automatic wait_drained();
    while (exp_cmd_q.size() > 0 || exp_rsp_q.size() > 0) @(posedge emif_usr_clk);
    #1;
  endtask

  // ------------------------------------------------------------
  // Checkers
  // ------------------------------------------------------------
  always @(posedge emif_usr_clk) begin
    cmd_t c;
    rsp_exp_t r;
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES) fail_run("Timeout: the run did not finish in time");
    if (reset_n_eclk) begin
      assert (!(ready && !status[STAT_RAM_INIT_DONE]))
        else fail_run("Ready was high before RAM init completed");
      assert (!(ready && !base_addr_vld))
        else fail_run("Ready was high while base_addr_vld was low");
      assert (!(mem_read && mem_write)) else fail_run("Read and write were issued together");
      if (mem_ready && mem_write && !status[STAT_RAM_INIT_DONE]) begin
        assert (mem_address == init_count[MAW-1:0] && init_count < WORDS)
          else fail_run($sformatf("MISMATCH mem_address got %h expected %h",
                                  mem_address, init_count));
        assert (mem_writedata == '0 && mem_byteenable == 8'hff)
          else fail_run($sformatf("MISMATCH init mem_writedata %h mem_byteenable %h",
                                  mem_writedata, mem_byteenable));
        init_count = init_count + 1;
      end else if (mem_ready && (mem_read || mem_write)) begin
        if (exp_cmd_q.size() == 0) fail_run("Memory command issued with no request queued");
        c = exp_cmd_q.pop_front();
        assert (mem_write == c.is_write && mem_address == c.addr)
          else fail_run($sformatf("MISMATCH mem_address got %h expected %h (write %h)",
                                  mem_address, c.addr, c.is_write));
        if (c.is_write) begin
          assert (mem_writedata == c.data && mem_byteenable == c.be &&
                  mem_write_poison == c.poison)
            else fail_run($sformatf("MISMATCH mem_writedata got %h expected %h",
                                    mem_writedata, c.data));
        end
      end
      if (readdatavalid) begin
        if (exp_rsp_q.size() == 0) fail_run("Response returned with no read outstanding");
        r = exp_rsp_q.pop_front();
        assert (readdata == r.data)
          else fail_run($sformatf("MISMATCH readdata got %h expected %h", readdata, r.data));
        assert (rsp_mdata == r.tag)
          else fail_run($sformatf("MISMATCH rsp_mdata got %h expected %h", rsp_mdata, r.tag));
        assert (read_poison == r.poison)
          else fail_run($sformatf("MISMATCH read_poison got %h expected %h",
                                  read_poison, r.poison));
      end
    end
  end

  // Status bits lag their inputs by one cycle
  logic [3:0] prev_emif;
  logic       prev_valid = 1'b0;
  always @(posedge emif_usr_clk) begin
    if (prev_valid) begin
      assert (status[3:0] == prev_emif)
        else fail_run($sformatf("MISMATCH status got %h expected %h", status[3:0], prev_emif));
    end
    prev_emif = {emif_pll_locked, emif_reset_done, emif_cal_success, emif_cal_fail};
    prev_valid = reset_n_eclk;
    #1;
    {emif_pll_locked, emif_reset_done, emif_cal_success, emif_cal_fail} = 4'($urandom);
  end

  // ------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------
  initial begin
    void'($urandom(32'h8f677bdc));
    reset_n_eclk = 1'b0;
    {base_addr, base_addr_vld, read, write, write_poison} = '0;
    {address, req_mdata, writedata, byteenable} = '0;
    {emif_pll_locked, emif_reset_done, emif_cal_success, emif_cal_fail} = '0;
    stall = 1'b0;
    cycles = 0;
    init_count = 0;
    next_tag = 14'($urandom);
    for (int i = 0; i < WORDS; i++) begin
      ref_data[i] = '0;
      ref_poison[i] = 1'b0;
    end
    repeat (10) @(posedge emif_usr_clk);
    #1 reset_n_eclk = 1'b1;
    // The base is valid during the fill so only init can hold ready low
    base_addr = 16'h0086;
    base_addr_vld = 1'b1;
    while (!status[STAT_RAM_INIT_DONE]) @(posedge emif_usr_clk);
    #1;
    // The base is withdrawn for a few cycles after init
    base_addr_vld = 1'b0;
    repeat (5) @(posedge emif_usr_clk);
    #1;
    base_addr_vld = 1'b1;

    // Write then read one word, then a partial byte-enable merge
    send(1'b1, 16'h0105, {$urandom, $urandom}, 8'hff, 1'b0);
    send(1'b0, 16'h0105, '0, '0, 1'b0);
    send(1'b1, 16'h0105, {$urandom, $urandom}, 8'h5a, 1'b1);
    send(1'b0, 16'h0105, '0, '0, 1'b0);
    wait_drained();

    // Random writes followed by back-to-back reads
    for (int i = 0; i < 16; i++) begin
      send(1'b1, 16'h0110 + 16'(i), {$urandom, $urandom}, 8'($urandom), 1'($urandom));
    end
    for (int i = 0; i < 16; i++) begin
      send(1'b0, 16'h0110 + 16'(i), '0, '0, 1'b0);
    end
    wait_drained();

    // Fill the request queue while the memory is stalled
    stall = 1'b1;
    repeat (2) @(posedge emif_usr_clk);
    #1;
    for (int i = 0; i < REQ_DEPTH; i++) begin
      send(1'(i % 2), 16'h0120 + 16'(i / 2), {$urandom, $urandom}, 8'hff, 1'($urandom));
    end
    assert (!ready) else fail_run("Ready stayed high with the request queue full");
    stall = 1'b0;
    wait_drained();
    repeat (10) @(posedge emif_usr_clk);

    if (init_count != WORDS || exp_cmd_q.size() != 0 || exp_rsp_q.size() != 0) begin
      fail_run("Init write count or outstanding requests wrong at end of run");
    end else begin
      $display("Verification passed");
      $finish;
    end
  end

endmodule

/* flist.f */
verilog/mc_adapter_pkg.sv
verilog/mc_sync_fifo.sv
verilog/mc_req_capture.sv
verilog/mc_init_status.sv
verilog/mc_mem_issue.sv
verilog/mc_rsp_path.sv
verilog/mc_channel_adapter.sv
verification/tb_mem_model.sv
verification/tb_mc_channel_adapter.sv

/* Makefile */
TOP := tb_mc_channel_adapter

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f flist.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Verification passed"

clean:
	rm -rf obj_dir
